/* src/rp_analog_pkg.sv */
`default_nettype none

package rp_analog_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADC_PIN_W    = 16;  // Full ADC pin word
  localparam int unsigned ADC_LSB_DROP = 2;   // Reserved low bits on 14-bit parts
  localparam int unsigned SAMPLE_W     = 14;  // Converter resolution

  ////////////////////////////////////////////////////////////
  // Sample types
  ////////////////////////////////////////////////////////////

  // Raw word as it sits on the ADC pins
  typedef logic [ADC_PIN_W-1:0] adc_pins_t;

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // Two's complement sample

  // Negative-slope offset code, converter side
  // Zero sample maps to 0x1FFF, +full scale to 0x0000
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  // One guard bit for the generator plus controller sum
  typedef logic signed [SAMPLE_W:0] dac_sum_t;

  ////////////////////////////////////////////////////////////
  // Channel pairs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    sample_t a;  // Channel 1
    sample_t b;  // Channel 2
  } sample_pair_t;

  typedef struct packed {
    adc_pins_t a;  // Channel 1 pins
    adc_pins_t b;  // Channel 2 pins
  } adc_pins_pair_t;

  typedef struct packed {
    dac_code_t a;  // Channel 1 code
    dac_code_t b;  // Channel 2 code
  } dac_code_pair_t;

endpackage

`default_nettype wire

/* src/adc_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_frontend (
  input  logic                          adc_clk,         // ADC sample clock
  input  logic                          reset_i,         // Sync reset, active high
  input  rp_analog_pkg::adc_pins_pair_t adc_pins_i,      // Raw pin words, both channels
  input  logic                          digital_loop_i,  // Loopback enable
  input  rp_analog_pkg::sample_pair_t   loop_dat_i,      // Saturated DAC samples
  output rp_analog_pkg::sample_pair_t   adc_dat_o        // Two's complement samples
);

  import rp_analog_pkg::*;

  dac_code_pair_t adc_raw;   // Upper pin bits, still in offset code
  sample_pair_t   adc_conv;  // After code conversion

  ////////////////////////////////////////////////////////////
  // Input register
  ////////////////////////////////////////////////////////////

  // Low bits are reserved on the 14-bit converter
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      adc_raw <= '0;  // Zero pins, reads back as +8191
    end
    else
    begin
      adc_raw.a <= adc_pins_i.a[ADC_PIN_W-1:ADC_LSB_DROP];
      adc_raw.b <= adc_pins_i.b[ADC_PIN_W-1:ADC_LSB_DROP];
    end
  end

  ////////////////////////////////////////////////////////////
  // Code conversion
  ////////////////////////////////////////////////////////////

  // Negative slope: top bit kept as sign, magnitude bits flipped
  always_comb
  begin
    adc_conv.a = sample_t'({adc_raw.a[SAMPLE_W-1], ~adc_raw.a[SAMPLE_W-2:0]});
    adc_conv.b = sample_t'({adc_raw.b[SAMPLE_W-1], ~adc_raw.b[SAMPLE_W-2:0]});
  end

  ////////////////////////////////////////////////////////////
  // Loopback select
  ////////////////////////////////////////////////////////////

  // Loop path bypasses the register, switches same cycle
  assign adc_dat_o = digital_loop_i ? loop_dat_i : adc_conv;

  // Cleared register reads back as +8191 on both channels
  a_reset_reads_max : assert property (
    @(posedge adc_clk) reset_i |=>
      (digital_loop_i || (adc_dat_o == {2{1'b0, {(SAMPLE_W-1){1'b1}}}}))
  )
  else
  begin
    $error("ADC data not +8191 after reset");
  end

endmodule

`default_nettype wire

/* src/dac_sat_sum.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_sat_sum (
  input  rp_analog_pkg::sample_t asg_i,  // Generator sample
  input  rp_analog_pkg::sample_t pid_i,  // Controller sample
  output rp_analog_pkg::sample_t sat_o   // Saturated sum
);

  import rp_analog_pkg::*;

  dac_sum_t sum;       // Full 15-bit sum
  logic     sum_ovf;   // Top two bits disagree
  sample_t  sum_sat;

  always_comb
  begin
    // Sign extend both before adding
    sum     = dac_sum_t'(asg_i) + dac_sum_t'(pid_i);
    sum_ovf = sum[SAMPLE_W] ^ sum[SAMPLE_W-1];
    if (sum_ovf)
    begin
      // Clip to +8191 or -8192 by the true sign
      sum_sat = {sum[SAMPLE_W], {(SAMPLE_W-1){~sum[SAMPLE_W]}}};
    end
    else
    begin
      sum_sat = sum[SAMPLE_W-1:0];  // Fits, drop guard bit
    end

    // Same-sign inputs never flip the output sign
    // Zero result is the only exception
    if ((asg_i[SAMPLE_W-1] == pid_i[SAMPLE_W-1]) && (sum_sat != '0))
    begin
      a_sign_kept : assert (sum_sat[SAMPLE_W-1] == asg_i[SAMPLE_W-1])
      else
      begin
        $error("Saturated sum lost the input sign");
      end
    end
  end

  assign sat_o = sum_sat;

endmodule

`default_nettype wire

/* src/dac_backend.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_backend (
  input  logic                          adc_clk,    // Shared data path clock
  input  logic                          reset_i,    // Sync reset, active high
  input  rp_analog_pkg::sample_pair_t   asg_dat_i,  // Generator samples
  input  rp_analog_pkg::sample_pair_t   pid_dat_i,  // Controller samples
  output rp_analog_pkg::sample_pair_t   sat_dat_o,  // Unregistered sums, to loopback
  output rp_analog_pkg::dac_code_pair_t dac_dat_o,  // Registered converter codes
  output logic                          dac_rst_o   // Registered converter reset
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////////////////////////
  // Saturating adders
  ////////////////////////////////////////////////////////////

  dac_sat_sum i_sat_a (
    .asg_i (asg_dat_i.a),  // CH 1
    .pid_i (pid_dat_i.a),
    .sat_o (sat_dat_o.a)
  );

  dac_sat_sum i_sat_b (
    .asg_i (asg_dat_i.b),  // CH 2
    .pid_i (pid_dat_i.b),
    .sat_o (sat_dat_o.b)
  );

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  // Back to negative-slope code on the way out
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      // Code of sample zero, 0x1FFF per channel
      dac_dat_o <= {2{1'b0, {(SAMPLE_W-1){1'b1}}}};
    end
    else
    begin
      dac_dat_o.a <= {sat_dat_o.a[SAMPLE_W-1], ~sat_dat_o.a[SAMPLE_W-2:0]};
      dac_dat_o.b <= {sat_dat_o.b[SAMPLE_W-1], ~sat_dat_o.b[SAMPLE_W-2:0]};
    end
  end

  // Converter reset trails reset_i by one cycle
  always_ff @(posedge adc_clk)
  begin
    dac_rst_o <= reset_i;
  end

  // Converter held in reset sees the zero-sample code
  a_dac_rst_follows : assert property (
    @(posedge adc_clk) reset_i |=>
      (dac_rst_o && (dac_dat_o == {2{1'b0, {(SAMPLE_W-1){1'b1}}}}))
  )
  else
  begin
    $error("DAC reset or zero code missing after reset cycle");
  end

endmodule

`default_nettype wire

/* src/rp_analog_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rp_analog_top (
  // Clock and reset
  input  logic                          adc_clk,         // ADC sample clock
  input  logic                          reset_i,         // Sync reset, active high

  // ADC side
  input  rp_analog_pkg::adc_pins_pair_t adc_pins_i,      // Raw ADC pin words
  input  logic                          digital_loop_i,  // Feed DAC samples back as ADC data
  output rp_analog_pkg::sample_pair_t   adc_dat_o,       // To scope and PID

  // Sample sources for the DAC
  input  rp_analog_pkg::sample_pair_t   asg_dat_i,       // Generator output
  input  rp_analog_pkg::sample_pair_t   pid_dat_i,       // Controller output

  // DAC side
  output rp_analog_pkg::dac_code_pair_t dac_dat_o,       // Parallel code, both channels
  output logic                          dac_rst_o        // Converter reset
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////////////////////////
  // Local signals
  ////////////////////////////////////////////////////////////

  // Saturated DAC samples, before the output register
  sample_pair_t loop_dat;

  ////////////////////////////////////////////////////////////
  // ADC front end
  ////////////////////////////////////////////////////////////

  // Pin register, offset-code conversion, loopback mux
  adc_frontend i_adc_frontend (
    .adc_clk        (adc_clk       ),
    .reset_i        (reset_i       ),
    .adc_pins_i     (adc_pins_i    ),
    .digital_loop_i (digital_loop_i),
    .loop_dat_i     (loop_dat      ),  // Back from DAC side
    .adc_dat_o      (adc_dat_o     )
  );

  ////////////////////////////////////////////////////////////
  // DAC back end
  ////////////////////////////////////////////////////////////

  // Sum, saturate, re-encode and register
  dac_backend i_dac_backend (
    .adc_clk   (adc_clk  ),  // DAC runs on ADC clock here
    .reset_i   (reset_i  ),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .sat_dat_o (loop_dat ),  // Loopback source
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

`default_nettype wire

/* dv/tb_rp_analog.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rp_analog;

  import rp_analog_pkg::*;

  localparam int          CLK_HALF     = 50;          // 100 ns period
  localparam int          RESET_CYCLES = 16;
  localparam int          RAND_END     = 216;         // Free random, loop off
  localparam int          SAT_END      = 316;         // Large same-sign samples
  localparam int          LOOP_END     = 416;         // Loopback toggling
  localparam int          TOTAL_CYCLES = 432;
  localparam int          WAIT_LIMIT   = 4 * CLK_HALF;
  localparam logic [31:0] LFSR_SEED    = 32'hc847;

  logic           adc_clk;
  logic           reset_i;
  adc_pins_pair_t adc_pins_i;
  logic           digital_loop_i;
  sample_pair_t   asg_dat_i;
  sample_pair_t   pid_dat_i;
  sample_pair_t   adc_dat_o;
  dac_code_pair_t dac_dat_o;
  logic           dac_rst_o;

  logic [31:0] lfsr_state;
  int          sat_hi_hits;   // Sums clipped to +8191
  int          sat_lo_hits;   // Sums clipped to -8192
  int          loop_checks;   // Cycles checked with loopback on

  rp_analog_top dut (
    .adc_clk        (adc_clk       ),
    .reset_i        (reset_i       ),
    .adc_pins_i     (adc_pins_i    ),
    .digital_loop_i (digital_loop_i),
    .asg_dat_i      (asg_dat_i     ),
    .pid_dat_i      (pid_dat_i     ),
    .adc_dat_o      (adc_dat_o     ),
    .dac_dat_o      (dac_dat_o     ),
    .dac_rst_o      (dac_rst_o     )
  );

  always #(CLK_HALF) adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] value;
    logic        fb;
    int          i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic int to_int(input logic [13:0] v);
    return v[13] ? int'(v) - 16384 : int'(v);  // Two's complement read
  endfunction

  // Clip to the 14-bit range
  function automatic int sat_model(input int a, input int b);
    int s;
    s = a + b;
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s;
  endfunction

  // Negative slope: code 0 is +full scale, 0x1FFF is zero
  function automatic logic [13:0] code_of(input int s);
    return 14'(8191 - s);
  endfunction

  function automatic int sample_of(input logic [13:0] code);
    return 8191 - int'(code);
  endfunction

  // Biased toward saturation, magnitude 4096 and up
  function automatic sample_t big_sample(input logic neg);
    int mag;
    mag = 4096 + int'(next_bits(12));
    return neg ? sample_t'(-mag) : sample_t'(mag);
  endfunction

  ////////////////////////////////////////////////////////////
  // Waits and checks
  ////////////////////////////////////////////////////////////

  // Main flow runs half a ns off the clock grid, so polling never races an edge
  task automatic wait_falling();
    int   ticks;
    logic seen_high;
    logic done;
    ticks     = 0;
    seen_high = 1'b0;
    done      = 1'b0;
    while (!done && ticks < WAIT_LIMIT)
    begin
      #1;
      ticks++;
      if (adc_clk === 1'b1)
        seen_high = 1'b1;
      else if (seen_high)
        done = 1'b1;  // High seen, now low again
    end
    assert (done)
    else
    begin
      $display("Timeout: no falling clock edge within %0d ns", WAIT_LIMIT);
      $display("Simulation FAILED");
      $fatal(1, "Clock stalled");
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
    assert (got === exp)
    else
    begin
      $display("Fail at %0.1f ns: %s expected %h got %h", $realtime, name, exp, got);
      $display("Simulation FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  // Registered outputs hold what the last rising edge took in
  task automatic check_outputs();
    int sat_a;
    int sat_b;
    int adc_a;
    int adc_b;
    sat_a = sat_model(to_int(asg_dat_i.a), to_int(pid_dat_i.a));
    sat_b = sat_model(to_int(asg_dat_i.b), to_int(pid_dat_i.b));
    if (digital_loop_i)
    begin
      adc_a = sat_a;  // Same-cycle loop path
      adc_b = sat_b;
      loop_checks++;
    end
    else if (reset_i)
    begin
      adc_a = sample_of(14'h0);  // Cleared pins
      adc_b = sample_of(14'h0);
    end
    else
    begin
      adc_a = sample_of(adc_pins_i.a[15:2]);  // Low pin bits ignored
      adc_b = sample_of(adc_pins_i.b[15:2]);
    end
    check_value("dac_rst_o", {15'h0, reset_i}, {15'h0, dac_rst_o});
    check_value("adc_dat_o.a", {2'b00, 14'(adc_a)}, {2'b00, adc_dat_o.a});
    check_value("adc_dat_o.b", {2'b00, 14'(adc_b)}, {2'b00, adc_dat_o.b});
    if (reset_i)
    begin
      check_value("dac_dat_o.a", 16'h1fff, {2'b00, dac_dat_o.a});
      check_value("dac_dat_o.b", 16'h1fff, {2'b00, dac_dat_o.b});
    end
    else
    begin
      check_value("dac_dat_o.a", {2'b00, code_of(sat_a)}, {2'b00, dac_dat_o.a});
      check_value("dac_dat_o.b", {2'b00, code_of(sat_b)}, {2'b00, dac_dat_o.b});
      if (sat_a == 8191 || sat_b == 8191)
        sat_hi_hits++;
      if (sat_a == -8192 || sat_b == -8192)
        sat_lo_hits++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_inputs(input int cyc);
    logic neg;
    reset_i      = (cyc < RESET_CYCLES);
    adc_pins_i.a = adc_pins_t'(next_bits(16));
    adc_pins_i.b = adc_pins_t'(next_bits(16));
    if (cyc >= RAND_END && cyc < SAT_END)
    begin
      neg         = next_bits(1) != 0;  // One sign per channel pair
      asg_dat_i.a = big_sample(neg);
      pid_dat_i.a = big_sample(neg);
      neg         = next_bits(1) != 0;
      asg_dat_i.b = big_sample(neg);
      pid_dat_i.b = big_sample(neg);
    end
    else
    begin
      asg_dat_i.a = sample_t'(next_bits(14));
      asg_dat_i.b = sample_t'(next_bits(14));
      pid_dat_i.a = sample_t'(next_bits(14));
      pid_dat_i.b = sample_t'(next_bits(14));
    end
    // Loop on about three cycles in four, with returns to ADC data
    digital_loop_i = (cyc >= SAT_END && cyc < LOOP_END) && (next_bits(2) != 0);
  endtask

  initial
  begin
    int cycle;
    lfsr_state  = LFSR_SEED;
    adc_clk     = 1'b0;
    sat_hi_hits = 0;
    sat_lo_hits = 0;
    loop_checks = 0;
    drive_inputs(0);  // Reset high from time zero
    #0.5;
    for (cycle = 1; cycle < TOTAL_CYCLES; cycle++)
    begin
      wait_falling();
      check_outputs();
      drive_inputs(cycle);
    end
    wait_falling();
    check_outputs();
    assert (sat_hi_hits > 0 && sat_lo_hits > 0)
    else
    begin
      $display("Saturation to both full-scale values was never reached");
      $display("Simulation FAILED");
      $fatal(1, "Saturation not covered");
    end
    assert (loop_checks > 0)
    else
    begin
      $display("Loopback was never checked");
      $display("Simulation FAILED");
      $fatal(1, "Loopback not covered");
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
src/rp_analog_pkg.sv
src/adc_frontend.sv
src/dac_sat_sum.sv
src/dac_backend.sv
src/rp_analog_top.sv
dv/tb_rp_analog.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the analog data path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_rp_analog \
  -f files.f \
  -o sim_rp_analog

./obj_dir/sim_rp_analog 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi

echo "Run finished, see sim.log"
exit 0
